// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    //////////////////////////////
    // cache status
    //////////////////////////////

    // _D variants write the dirty victim back before the refill
    typedef enum logic [2:0] {
        STAT_NORMAL        = 3'd0,
        STAT_IC_MISS       = 3'd1,
        STAT_DC_MISS       = 3'd2,
        STAT_DC_MISS_D     = 3'd3,
        STAT_DOUBLE_MISS   = 3'd4,
        STAT_DOUBLE_MISS_D = 3'd5
    } cache_status_t;

    //////////////////////////////
    // line geometry
    //////////////////////////////

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_SEL_W     = 3;
    localparam int BYTE_EN_W      = 4;

    // byte offset in a word, then word offset in a line
    localparam int BYTE_OFF_W = 2;
    localparam int LINE_OFF_W = WORD_SEL_W + BYTE_OFF_W;

    localparam logic [WORD_SEL_W-1:0] COUNT_FINISH = WORD_SEL_W'(WORDS_PER_LINE - 1);

    // memory address source, bit 1 = write-back, bit 0 = data cache
    localparam logic [1:0] RAM_SEL_IC    = 2'b00;
    localparam logic [1:0] RAM_SEL_DC    = 2'b01;
    localparam logic [1:0] RAM_SEL_DC_WB = 2'b11;

endpackage

`default_nettype wire

// File: cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  wire                             ic_read,
    input  wire                             dc_read,
    input  wire                             dc_write,
    input  wire                             ic_hit,
    input  wire                             ic_valid,
    input  wire                             dc_hit,
    input  wire                             dc_dirty,
    input  wire                             dc_valid,
    input  wire cache_pkg::cache_status_t   status,
    input  wire [cache_pkg::WORD_SEL_W-1:0] counter,
    input  wire [cache_pkg::WORD_SEL_W-1:0] ic_word_sel,
    input  wire [cache_pkg::WORD_SEL_W-1:0] dc_word_sel,
    input  wire [cache_pkg::BYTE_EN_W-1:0]  dc_byte_w_en,
    output logic                            ic_enable,
    output logic                            ic_cmp,
    output logic                            ic_write,
    output logic                            ic_valid_in,
    output logic                            dc_enable,
    output logic                            dc_cmp,
    output logic                            dc_write_out,
    output logic                            dc_valid_in,
    output logic                            ram_en,
    output logic                            ram_write,
    output logic [1:0]                      ram_addr_sel,
    output cache_pkg::cache_status_t        status_next,
    output logic [cache_pkg::WORD_SEL_W-1:0] counter_next,
    output logic [cache_pkg::WORD_SEL_W-1:0] ic_word_sel_out,
    output logic [cache_pkg::WORD_SEL_W-1:0] dc_word_sel_out,
    output logic [cache_pkg::BYTE_EN_W-1:0] ic_byte_w_en,
    output logic [cache_pkg::BYTE_EN_W-1:0] dc_byte_w_en_out
);
    import cache_pkg::*;

    logic last_word;
    logic ic_miss;
    logic dc_miss;

    assign last_word = (counter == COUNT_FINISH);

    // miss terms only matter in normal status
    assign ic_miss = ic_read & ~(ic_hit & ic_valid);
    assign dc_miss = (dc_read | dc_write) & ~(dc_hit & dc_valid);

    always_comb begin
        // idle caches and memory, counter steps through the line
        ic_enable        = 1'b0;
        ic_cmp           = 1'b0;
        ic_write         = 1'b0;
        ic_valid_in      = 1'b1;
        ic_word_sel_out  = counter;
        ic_byte_w_en     = '0;
        dc_enable        = 1'b0;
        dc_cmp           = 1'b0;
        dc_write_out     = 1'b0;
        dc_valid_in      = 1'b1;
        dc_word_sel_out  = counter;
        dc_byte_w_en_out = '0;
        ram_en           = 1'b0;
        ram_write        = 1'b0;
        ram_addr_sel     = RAM_SEL_IC;
        status_next      = status;
        counter_next     = last_word ? '0 : counter + 1'b1;

        case (status)
            STAT_IC_MISS, STAT_DOUBLE_MISS: begin
                // refill icache, dcache looked up on the same line
                ic_enable    = 1'b1;
                ic_write     = 1'b1;
                ic_byte_w_en = '1;
                dc_enable    = 1'b1;
                dc_cmp       = 1'b1;
                // memory idle when dcache supplies the words
                ram_en       = ~(dc_hit & dc_valid);
                ram_addr_sel = RAM_SEL_IC;
                if (last_word) begin
                    status_next = (status == STAT_DOUBLE_MISS) ? STAT_DC_MISS : STAT_NORMAL;
                end
            end
            STAT_DC_MISS: begin
                dc_enable        = 1'b1;
                dc_write_out     = 1'b1;
                dc_byte_w_en_out = '1;
                ram_en           = 1'b1;
                ram_addr_sel     = RAM_SEL_DC;
                if (last_word) begin
                    status_next = STAT_NORMAL;
                end
            end
            STAT_DC_MISS_D, STAT_DOUBLE_MISS_D: begin
                // victim words out of dcache into memory
                dc_enable    = 1'b1;
                ram_en       = 1'b1;
                ram_write    = 1'b1;
                ram_addr_sel = RAM_SEL_DC_WB;
                if (last_word) begin
                    status_next = (status == STAT_DOUBLE_MISS_D) ? STAT_DOUBLE_MISS
                                                                 : STAT_DC_MISS;
                end
            end
            default: begin
                // normal: serve the cpu, pick the next status by priority
                ic_enable        = ic_read;
                ic_cmp           = 1'b1;
                ic_word_sel_out  = ic_word_sel;
                dc_enable        = dc_read | dc_write;
                dc_cmp           = 1'b1;
                dc_write_out     = dc_write;
                dc_word_sel_out  = dc_word_sel;
                dc_byte_w_en_out = dc_byte_w_en;
                counter_next     = '0;
                if (dc_miss && ic_miss) begin
                    status_next = dc_dirty ? STAT_DOUBLE_MISS_D : STAT_DOUBLE_MISS;
                end else if (dc_miss) begin
                    status_next = dc_dirty ? STAT_DC_MISS_D : STAT_DC_MISS;
                end else if (ic_miss) begin
                    status_next = STAT_IC_MISS;
                end else begin
                    status_next = STAT_NORMAL;
                end
            end
        endcase
    end

    // every phase starts from word 0, so normal never sees a moved counter
    always_comb begin
        assert final (status != STAT_NORMAL || counter == '0)
            else $error("word counter nonzero in normal status");
    end

endmodule

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int INDEX_W = 4
) (
    input  wire                                                  clk,
    input  wire                                                  reset,
    input  wire [INDEX_W-1:0]                                    index,
    input  wire [cache_pkg::ADDR_W-INDEX_W-cache_pkg::LINE_OFF_W-1:0] tag,
    input  wire [cache_pkg::WORD_SEL_W-1:0]                      word_sel,
    input  wire                                                  enable,
    input  wire                                                  cmp,
    input  wire                                                  write,
    input  wire                                                  valid_in,
    input  wire [cache_pkg::BYTE_EN_W-1:0]                       byte_w_en,
    input  wire [cache_pkg::DATA_W-1:0]                          wdata,
    input  wire                                                  way_sel,
    input  wire                                                  last_word,
    output logic                                                 hit,
    output logic                                                 valid,
    output logic                                                 dirty,
    output logic [cache_pkg::DATA_W-1:0]                         rdata,
    output logic [cache_pkg::ADDR_W-INDEX_W-cache_pkg::LINE_OFF_W-1:0] tag_out
);
    import cache_pkg::*;

    localparam int SETS  = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - LINE_OFF_W;

    logic [TAG_W-1:0]  tag_mem  [SETS];
    logic [DATA_W-1:0] data_mem [SETS*WORDS_PER_LINE];
    logic [SETS-1:0]   valid_bits;
    logic [SETS-1:0]   dirty_bits;
    logic              do_write;

    assign tag_out = tag_mem[index];
    assign valid   = valid_bits[index];
    assign dirty   = dirty_bits[index];
    assign rdata   = data_mem[{index, word_sel}];
    assign hit     = enable & cmp & valid & (tag_out == tag);

    // cpu store on a hit, or refill when this way is the victim
    assign do_write = enable & write & (cmp ? hit : way_sel);

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < BYTE_EN_W; b++) begin
                if (byte_w_en[b]) begin
                    data_mem[{index, word_sel}][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // new tag becomes visible once the whole line is in
    always_ff @(posedge clk) begin
        if (do_write && !cmp && last_word) begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (do_write) begin
            if (cmp) begin
                dirty_bits[index] <= 1'b1;
            end else if (last_word) begin
                valid_bits[index] <= valid_in;
                dirty_bits[index] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_set_assoc.sv
`timescale 1ns/1ps
`default_nettype none

module cache_set_assoc #(
    parameter int NUM_WAYS = 2,
    parameter int INDEX_W  = 4
) (
    input  wire                                                  clk,
    input  wire                                                  reset,
    input  wire [cache_pkg::ADDR_W-1:0]                          addr,
    input  wire [cache_pkg::WORD_SEL_W-1:0]                      word_sel,
    input  wire                                                  enable,
    input  wire                                                  cmp,
    input  wire                                                  write,
    input  wire                                                  valid_in,
    input  wire [cache_pkg::BYTE_EN_W-1:0]                       byte_w_en,
    input  wire [cache_pkg::DATA_W-1:0]                          wdata,
    output logic                                                 hit,
    output logic                                                 valid,
    output logic                                                 dirty,
    output logic [cache_pkg::DATA_W-1:0]                         rdata,
    output logic [cache_pkg::ADDR_W-INDEX_W-cache_pkg::LINE_OFF_W-1:0] victim_tag
);
    import cache_pkg::*;

    localparam int SETS  = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - LINE_OFF_W;
    localparam int WAY_W = $clog2(NUM_WAYS);

    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic               last_word;
    logic [WAY_W-1:0]   victim_ptr [SETS];
    logic [WAY_W-1:0]   victim;
    logic [WAY_W-1:0]   sel_way;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_WAYS-1:0] valid_vec;
    logic [NUM_WAYS-1:0] dirty_vec;
    logic [DATA_W-1:0]   rdata_vec [NUM_WAYS];
    logic [TAG_W-1:0]    tag_vec   [NUM_WAYS];

    assign tag       = addr[ADDR_W-1 -: TAG_W];
    assign index     = addr[LINE_OFF_W +: INDEX_W];
    assign last_word = (word_sel == COUNT_FINISH);
    assign victim    = victim_ptr[index];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .INDEX_W(INDEX_W)
        ) way_i (
            .clk       (clk),
            .reset     (reset),
            .index     (index),
            .tag       (tag),
            .word_sel  (word_sel),
            .enable    (enable),
            .cmp       (cmp),
            .write     (write),
            .valid_in  (valid_in),
            .byte_w_en (byte_w_en),
            .wdata     (wdata),
            .way_sel   (victim == WAY_W'(w)),
            .last_word (last_word),
            .hit       (hit_vec[w]),
            .valid     (valid_vec[w]),
            .dirty     (dirty_vec[w]),
            .rdata     (rdata_vec[w]),
            .tag_out   (tag_vec[w])
        );
    end

    // hitting way if any, else the victim way
    always_comb begin
        sel_way = victim;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                sel_way = WAY_W'(w);
            end
        end
    end

    assign hit        = |hit_vec;
    assign valid      = valid_vec[sel_way];
    assign dirty      = dirty_vec[sel_way];
    assign rdata      = rdata_vec[sel_way];
    assign victim_tag = tag_vec[victim];

    // round robin, moves on when the refill writes its last word
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                victim_ptr[s] <= '0;
            end
        end else if (enable && write && !cmp && last_word) begin
            victim_ptr[index] <= victim_ptr[index] + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec))
        else $error("more than one way hit in the same set");

endmodule

`default_nettype wire

// File: cache_manage_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cache_manage_unit #(
    parameter int NUM_WAYS = 2,
    parameter int INDEX_W  = 4
) (
    input  wire                             clk,
    input  wire                             reset,
    // instruction side
    input  wire                             ic_read,
    input  wire [cache_pkg::ADDR_W-1:0]     ic_addr,
    output logic [cache_pkg::DATA_W-1:0]    ic_rdata,
    // data side
    input  wire                             dc_read,
    input  wire                             dc_write,
    input  wire [cache_pkg::ADDR_W-1:0]     dc_addr,
    input  wire [cache_pkg::BYTE_EN_W-1:0]  dc_byte_w_en,
    input  wire [cache_pkg::DATA_W-1:0]     dc_wdata,
    output logic [cache_pkg::DATA_W-1:0]    dc_rdata,
    output logic                            stall,
    // memory port
    output logic                            ram_en,
    output logic                            ram_write,
    output logic [cache_pkg::ADDR_W-1:0]    ram_addr,
    output logic [cache_pkg::DATA_W-1:0]    ram_wdata,
    input  wire [cache_pkg::DATA_W-1:0]     ram_rdata
);
    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - LINE_OFF_W;

    cache_status_t         status;
    cache_status_t         status_next;
    logic [WORD_SEL_W-1:0] counter;
    logic [WORD_SEL_W-1:0] counter_next;
    logic [1:0]            ram_addr_sel;
    logic                  ic_filling;

    logic                  ic_enable;
    logic                  ic_cmp;
    logic                  ic_write;
    logic                  ic_valid_in;
    logic                  ic_hit;
    logic                  ic_valid;
    logic [WORD_SEL_W-1:0] ic_word_sel_out;
    logic [BYTE_EN_W-1:0]  ic_byte_w_en;
    logic [DATA_W-1:0]     ic_fill_data;

    logic                  dc_enable;
    logic                  dc_cmp;
    logic                  dc_write_ctl;
    logic                  dc_valid_in;
    logic                  dc_hit;
    logic                  dc_valid;
    logic                  dc_dirty;
    logic [WORD_SEL_W-1:0] dc_word_sel_out;
    logic [BYTE_EN_W-1:0]  dc_byte_w_en_out;
    logic [ADDR_W-1:0]     dc_cache_addr;
    logic [DATA_W-1:0]     dc_cache_wdata;
    logic [TAG_W-1:0]      dc_victim_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            status  <= STAT_NORMAL;
            counter <= '0;
        end else begin
            status  <= status_next;
            counter <= counter_next;
        end
    end

    assign stall = (status_next != STAT_NORMAL) || (status != STAT_NORMAL);

    //////////////////////////////
    // data steering
    //////////////////////////////

    assign ic_filling = (status == STAT_IC_MISS) || (status == STAT_DOUBLE_MISS);

    // during an icache fill the dcache is probed with the instruction line
    assign dc_cache_addr  = ic_filling ? ic_addr : dc_addr;
    assign ic_fill_data   = (ic_filling && dc_hit && dc_valid) ? dc_rdata : ram_rdata;
    assign dc_cache_wdata = (status == STAT_NORMAL) ? dc_wdata : ram_rdata;
    assign ram_wdata      = dc_rdata;

    always_comb begin
        case (ram_addr_sel)
            RAM_SEL_DC: begin
                ram_addr = {dc_addr[ADDR_W-1:LINE_OFF_W], counter, {BYTE_OFF_W{1'b0}}};
            end
            RAM_SEL_DC_WB: begin
                ram_addr = {dc_victim_tag, dc_addr[LINE_OFF_W +: INDEX_W], counter,
                            {BYTE_OFF_W{1'b0}}};
            end
            default: begin
                ram_addr = {ic_addr[ADDR_W-1:LINE_OFF_W], counter, {BYTE_OFF_W{1'b0}}};
            end
        endcase
    end

    //////////////////////////////
    // control and caches
    //////////////////////////////

    cache_control cache_control_i (
        .ic_read          (ic_read),
        .dc_read          (dc_read),
        .dc_write         (dc_write),
        .ic_hit           (ic_hit),
        .ic_valid         (ic_valid),
        .dc_hit           (dc_hit),
        .dc_dirty         (dc_dirty),
        .dc_valid         (dc_valid),
        .status           (status),
        .counter          (counter),
        .ic_word_sel      (ic_addr[LINE_OFF_W-1:BYTE_OFF_W]),
        .dc_word_sel      (dc_addr[LINE_OFF_W-1:BYTE_OFF_W]),
        .dc_byte_w_en     (dc_byte_w_en),
        .ic_enable        (ic_enable),
        .ic_cmp           (ic_cmp),
        .ic_write         (ic_write),
        .ic_valid_in      (ic_valid_in),
        .dc_enable        (dc_enable),
        .dc_cmp           (dc_cmp),
        .dc_write_out     (dc_write_ctl),
        .dc_valid_in      (dc_valid_in),
        .ram_en           (ram_en),
        .ram_write        (ram_write),
        .ram_addr_sel     (ram_addr_sel),
        .status_next      (status_next),
        .counter_next     (counter_next),
        .ic_word_sel_out  (ic_word_sel_out),
        .dc_word_sel_out  (dc_word_sel_out),
        .ic_byte_w_en     (ic_byte_w_en),
        .dc_byte_w_en_out (dc_byte_w_en_out)
    );

    cache_set_assoc #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_W (INDEX_W)
    ) icache (
        .clk        (clk),
        .reset      (reset),
        .addr       (ic_addr),
        .word_sel   (ic_word_sel_out),
        .enable     (ic_enable),
        .cmp        (ic_cmp),
        .write      (ic_write),
        .valid_in   (ic_valid_in),
        .byte_w_en  (ic_byte_w_en),
        .wdata      (ic_fill_data),
        .hit        (ic_hit),
        .valid      (ic_valid),
        .dirty      (),
        .rdata      (ic_rdata),
        .victim_tag ()
    );

    cache_set_assoc #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_W (INDEX_W)
    ) dcache (
        .clk        (clk),
        .reset      (reset),
        .addr       (dc_cache_addr),
        .word_sel   (dc_word_sel_out),
        .enable     (dc_enable),
        .cmp        (dc_cmp),
        .write      (dc_write_ctl),
        .valid_in   (dc_valid_in),
        .byte_w_en  (dc_byte_w_en_out),
        .wdata      (dc_cache_wdata),
        .hit        (dc_hit),
        .valid      (dc_valid),
        .dirty      (dc_dirty),
        .rdata      (dc_rdata),
        .victim_tag (dc_victim_tag)
    );

    // memory is written only while a dirty victim drains
    assert property (@(posedge clk) disable iff (reset)
        ram_write |-> (status inside {STAT_DC_MISS_D, STAT_DOUBLE_MISS_D})
                      && dc_valid && dc_dirty)
        else $error("memory write outside a dirty write-back phase");

endmodule

`default_nettype wire

// File: tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
    import cache_pkg::*;

    localparam int NUM_WAYS  = 2;
    localparam int INDEX_W   = 4;
    localparam int MEM_AW    = 12;
    localparam int NUM_TESTS = 6;

    logic                 clk;
    logic                 reset;
    logic                 ic_read;
    logic [ADDR_W-1:0]    ic_addr;
    logic [DATA_W-1:0]    ic_rdata;
    logic                 dc_read;
    logic                 dc_write;
    logic [ADDR_W-1:0]    dc_addr;
    logic [BYTE_EN_W-1:0] dc_byte_w_en;
    logic [DATA_W-1:0]    dc_wdata;
    logic [DATA_W-1:0]    dc_rdata;
    logic                 stall;
    logic                 ram_en;
    logic                 ram_write;
    logic [ADDR_W-1:0]    ram_addr;
    logic [DATA_W-1:0]    ram_wdata;
    logic [DATA_W-1:0]    ram_rdata;

    // memory model and the contents the cpu expects to read back
    logic [DATA_W-1:0] mem     [1 << MEM_AW];
    logic [DATA_W-1:0] exp_mem [1 << MEM_AW];
    int                ram_cycles = 0;
    logic [DATA_W-1:0] ic_seen;
    logic [DATA_W-1:0] dc_seen;
    int                stall_cycles;

    cache_manage_unit #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_W (INDEX_W)
    ) cache_manage_unit_i (
        .clk          (clk),
        .reset        (reset),
        .ic_read      (ic_read),
        .ic_addr      (ic_addr),
        .ic_rdata     (ic_rdata),
        .dc_read      (dc_read),
        .dc_write     (dc_write),
        .dc_addr      (dc_addr),
        .dc_byte_w_en (dc_byte_w_en),
        .dc_wdata     (dc_wdata),
        .dc_rdata     (dc_rdata),
        .stall        (stall),
        .ram_en       (ram_en),
        .ram_write    (ram_write),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    // reads answer in the same cycle
    assign ram_rdata = mem[ram_addr[MEM_AW+1:2]];

    always @(posedge clk) begin
        if (ram_en) begin
            ram_cycles <= ram_cycles + 1;
        end
        // write-back words must carry the latest cpu data
        if (ram_en && ram_write) begin
            check_value("ram_wdata", exp_mem[ram_addr[MEM_AW+1:2]], ram_wdata);
            mem[ram_addr[MEM_AW+1:2]] <= ram_wdata;
        end
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Simulation failed");
        $fatal(1, "run did not complete within %0d cycles", NUM_TESTS * 200);
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return exp_mem[addr[MEM_AW+1:2]];
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [BYTE_EN_W-1:0] be);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BYTE_EN_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // present a request, hold it through the stall, count stalled cycles
    task automatic cpu_request(input logic ic_rd, input logic [ADDR_W-1:0] ic_a,
                               input logic dc_rd, input logic dc_wr,
                               input logic [ADDR_W-1:0] dc_a,
                               input logic [BYTE_EN_W-1:0] be,
                               input logic [DATA_W-1:0] wd);
        int n;
        n = 0;
        @(posedge clk);
        ic_read      <= ic_rd;
        ic_addr      <= ic_a;
        dc_read      <= dc_rd;
        dc_write     <= dc_wr;
        dc_addr      <= dc_a;
        dc_byte_w_en <= be;
        dc_wdata     <= wd;
        @(negedge clk);
        while (stall) begin
            n++;
            @(negedge clk);
        end
        ic_seen      = ic_rdata;
        dc_seen      = dc_rdata;
        stall_cycles = n;
        // a store commits at this edge
        @(posedge clk);
        ic_read  <= 1'b0;
        dc_read  <= 1'b0;
        dc_write <= 1'b0;
        if (dc_wr) begin
            exp_mem[dc_a[MEM_AW+1:2]] = merge_bytes(exp_mem[dc_a[MEM_AW+1:2]], wd, be);
        end
    endtask

    task automatic ic_fetch(input logic [ADDR_W-1:0] addr);
        cpu_request(1'b1, addr, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic dc_load(input logic [ADDR_W-1:0] addr);
        cpu_request(1'b0, '0, 1'b1, 1'b0, addr, '0, '0);
    endtask

    task automatic dc_store(input logic [ADDR_W-1:0] addr, input logic [BYTE_EN_W-1:0] be,
                            input logic [DATA_W-1:0] wd);
        cpu_request(1'b0, '0, 1'b0, 1'b1, addr, be, wd);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic idle_after_reset();
        @(negedge clk);
        check_value("stall", 0, 32'(stall));
        check_value("ram_en", 0, 32'(ram_en));
        check_value("ram_write", 0, 32'(ram_write));
    endtask

    task automatic ifetch_miss_then_hit();
        // one miss cycle plus an 8 word fill
        ic_fetch(32'h0000_0040);
        check_value("stall cycles", 32'd9, stall_cycles);
        check_value("ic_rdata", expected_word(32'h0000_0040), ic_seen);
        ic_fetch(32'h0000_0054);
        check_value("stall cycles", 0, stall_cycles);
        check_value("ic_rdata", expected_word(32'h0000_0054), ic_seen);
    endtask

    task automatic byte_write_merge();
        dc_load(32'h0000_0064);
        check_value("stall cycles", 32'd9, stall_cycles);
        check_value("dc_rdata", expected_word(32'h0000_0064), dc_seen);
        dc_store(32'h0000_0064, 4'b0101, $urandom);
        check_value("stall cycles", 0, stall_cycles);
        dc_load(32'h0000_0064);
        check_value("stall cycles", 0, stall_cycles);
        check_value("dc_rdata", expected_word(32'h0000_0064), dc_seen);
    endtask

    task automatic dirty_line_eviction();
        logic [ADDR_W-1:0] conflict;
        dc_store(32'h0000_0088, 4'b1111, $urandom);
        check_value("stall cycles", 32'd9, stall_cycles);
        dc_store(32'h0000_009c, 4'b1100, $urandom);
        check_value("stall cycles", 0, stall_cycles);
        // same index, new tags, the last one pushes the dirty line out
        for (int k = 1; k <= NUM_WAYS; k++) begin
            conflict = 32'h0000_0088 + 32'(k) * 32'h200;
            dc_load(conflict);
            check_value("stall cycles", (k == NUM_WAYS) ? 32'd17 : 32'd9, stall_cycles);
            check_value("dc_rdata", expected_word(conflict), dc_seen);
        end
        check_value("memory word", expected_word(32'h0000_0088), mem[32'h88 >> 2]);
        dc_load(32'h0000_0088);
        check_value("dc_rdata", expected_word(32'h0000_0088), dc_seen);
    endtask

    task automatic icache_fill_from_dcache();
        int ram_before;
        dc_store(32'h0000_00a8, 4'b1111, $urandom);
        @(negedge clk);
        ram_before = ram_cycles;
        ic_fetch(32'h0000_00a8);
        @(negedge clk);
        check_value("stall cycles", 32'd9, stall_cycles);
        check_value("ic_rdata", expected_word(32'h0000_00a8), ic_seen);
        check_value("ram_en cycles", 32'(ram_before), 32'(ram_cycles));
    endtask

    task automatic double_miss_sequence();
        logic [ADDR_W-1:0] dc_target;
        dc_store(32'h0000_00c0, 4'b1111, $urandom);
        for (int k = 1; k < NUM_WAYS; k++) begin
            dc_load(32'h0000_00c0 + 32'(k) * 32'h200);
        end
        // victim of the data set is now the dirty line
        dc_target = 32'h0000_00c4 + 32'(NUM_WAYS) * 32'h200;
        cpu_request(1'b1, 32'h0000_0e00, 1'b1, 1'b0, dc_target, '0, '0);
        check_value("stall cycles", 32'd25, stall_cycles);
        check_value("ic_rdata", expected_word(32'h0000_0e00), ic_seen);
        check_value("dc_rdata", expected_word(dc_target), dc_seen);
    endtask

    initial begin
        logic [DATA_W-1:0] word;
        void'($urandom(15869));
        reset        = 1'b1;
        ic_read      = 1'b0;
        ic_addr      = '0;
        dc_read      = 1'b0;
        dc_write     = 1'b0;
        dc_addr      = '0;
        dc_byte_w_en = '0;
        dc_wdata     = '0;
        for (int i = 0; i < (1 << MEM_AW); i++) begin
            word       = $urandom;
            exp_mem[i] = word;
            mem[i]    <= word;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset();
        ifetch_miss_then_hit();
        byte_write_merge();
        dirty_line_eviction();
        icache_fill_from_dcache();
        double_miss_sequence();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
cache_pkg.sv
cache_control.sv
cache_way.sv
cache_set_assoc.sv
cache_manage_unit.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
